// ==== dv/itcm_sram_model.sv ====
`timescale 1ns/1ns

module itcm_sram_model
  import itcm_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_cs,
  input  logic                   i_we,
  input  logic [ITCM_RAM_AW-1:0] i_addr,
  input  logic [ITCM_WMSK_W-1:0] i_wem,
  input  logic [ITCM_DATA_W-1:0] i_din,
  output logic [ITCM_DATA_W-1:0] o_dout
);

  logic [ITCM_DATA_W-1:0] mem [0:(1<<ITCM_RAM_AW)-1];

  // Fill pattern carries the full row number in both halves
  initial begin
    logic [ITCM_RAM_AW-1:0] row;
    for (int i = 0; i < (1 << ITCM_RAM_AW); i++) begin
      row = ITCM_RAM_AW'(i);
      mem[i] = {16'hC0DE, 3'b000, row, 16'hF00D, 3'b000, row};
    end
    o_dout = '0;
  end

  //////////////////////////////////////////////////
  // Single port access
  //////////////////////////////////////////////////

  // Output only moves on a read, so it holds while cs is low
  always @(posedge i_clk) begin
    if (i_cs) begin
      if (i_we) begin
        for (int b = 0; b < ITCM_WMSK_W; b++) begin
          if (i_wem[b]) begin
            mem[i_addr][b*8 +: 8] <= i_din[b*8 +: 8];
          end
        end
      end else begin
        o_dout <= mem[i_addr];
      end
    end
  end

endmodule

// ==== dv/tb_itcm_ctrl.sv ====
`timescale 1ns/1ns

module tb_itcm_ctrl
  import itcm_pkg::*;
();

  logic                   clk;
  logic                   rst_n;
  logic                   ifu_cmd_valid;
  logic                   o_ifu_cmd_ready;
  logic [ITCM_ADDR_W-1:0] ifu_cmd_addr;
  logic                   ifu_cmd_read;
  logic [ITCM_DATA_W-1:0] ifu_cmd_wdata;
  logic [ITCM_WMSK_W-1:0] ifu_cmd_wmask;
  logic                   o_ifu_rsp_valid;
  logic                   ifu_rsp_ready;
  logic [ITCM_DATA_W-1:0] o_ifu_rsp_rdata;
  logic                   o_ifu_holdup;
  logic                   lsu_cmd_valid;
  logic                   o_lsu_cmd_ready;
  logic [ITCM_ADDR_W-1:0] lsu_cmd_addr;
  logic                   lsu_cmd_read;
  logic [LSU_DATA_W-1:0]  lsu_cmd_wdata;
  logic [LSU_WMSK_W-1:0]  lsu_cmd_wmask;
  logic                   o_lsu_rsp_valid;
  logic                   lsu_rsp_ready;
  logic [LSU_DATA_W-1:0]  o_lsu_rsp_rdata;
  logic                   ram_cs;
  logic                   ram_we;
  logic [ITCM_RAM_AW-1:0] ram_addr;
  logic [ITCM_WMSK_W-1:0] ram_wem;
  logic [ITCM_DATA_W-1:0] ram_din;
  logic [ITCM_DATA_W-1:0] ram_dout;
  logic                   o_itcm_active;

  int seed;
  int errors;
  int checks;
  int phase;
  int ifu_stall;
  int lsu_stall;
  bit stuck;
  bit ifu_took;
  bit lsu_took;
  bit ifu_held;
  bit lsu_held;
  logic [ITCM_DATA_W-1:0] ifu_held_data;
  logic [LSU_DATA_W-1:0]  lsu_held_data;

  // Reference memory over the 32 rows that the stimulus touches
  itcm_word_u             ref_mem [0:31];
  logic [ITCM_DATA_W-1:0] ifu_exp_q [$];
  bit                     ifu_rd_q [$];
  logic [LSU_DATA_W-1:0]  lsu_exp_q [$];
  bit                     lsu_rd_q [$];

  itcm_ctrl i_itcm_ctrl (
    .i_clk           (clk),
    .i_rst_n         (rst_n),
    .i_ifu_cmd_valid (ifu_cmd_valid),
    .o_ifu_cmd_ready (o_ifu_cmd_ready),
    .i_ifu_cmd_addr  (ifu_cmd_addr),
    .i_ifu_cmd_read  (ifu_cmd_read),
    .i_ifu_cmd_wdata (ifu_cmd_wdata),
    .i_ifu_cmd_wmask (ifu_cmd_wmask),
    .o_ifu_rsp_valid (o_ifu_rsp_valid),
    .i_ifu_rsp_ready (ifu_rsp_ready),
    .o_ifu_rsp_rdata (o_ifu_rsp_rdata),
    .o_ifu_holdup    (o_ifu_holdup),
    .i_lsu_cmd_valid (lsu_cmd_valid),
    .o_lsu_cmd_ready (o_lsu_cmd_ready),
    .i_lsu_cmd_addr  (lsu_cmd_addr),
    .i_lsu_cmd_read  (lsu_cmd_read),
    .i_lsu_cmd_wdata (lsu_cmd_wdata),
    .i_lsu_cmd_wmask (lsu_cmd_wmask),
    .o_lsu_rsp_valid (o_lsu_rsp_valid),
    .i_lsu_rsp_ready (lsu_rsp_ready),
    .o_lsu_rsp_rdata (o_lsu_rsp_rdata),
    .o_ram_cs        (ram_cs),
    .o_ram_we        (ram_we),
    .o_ram_addr      (ram_addr),
    .o_ram_wem       (ram_wem),
    .o_ram_din       (ram_din),
    .i_ram_dout      (ram_dout),
    .o_itcm_active   (o_itcm_active)
  );

  itcm_sram_model u_sram (
    .i_clk  (clk),
    .i_cs   (ram_cs),
    .i_we   (ram_we),
    .i_addr (ram_addr),
    .i_wem  (ram_wem),
    .i_din  (ram_din),
    .o_dout (ram_dout)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic report_mismatch(string name, logic [63:0] exp, logic [63:0] act);
    $display("ERR %s expected %h actual %h", name, exp, act);
    errors++;
  endtask

  task automatic report_failure(string what);
    $display("ERROR: %s", what);
    errors++;
  endtask

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Phase 0 IFU only, 1 LSU traffic with IFU reads, 2 all mixed, 3 drain
  task automatic drive_inputs();
    int r;
    if (!ifu_cmd_valid || ifu_took) begin
      r = $random(seed);
      case (phase)
        0:       ifu_cmd_valid = r[0] | r[1];
        1:       ifu_cmd_valid = r[0] & r[1];
        2:       ifu_cmd_valid = r[0];
        default: ifu_cmd_valid = 1'b0;
      endcase
      ifu_cmd_addr  = {8'h00, r[15:8]};
      ifu_cmd_read  = (phase == 1) ? 1'b1 : r[2];
      ifu_cmd_wmask = r[23:16];
      ifu_cmd_wdata = {$random(seed), $random(seed)};
    end
    if (!lsu_cmd_valid || lsu_took) begin
      r = $random(seed);
      lsu_cmd_valid = (phase == 1 || phase == 2) ? (r[0] | r[1]) : 1'b0;
      lsu_cmd_addr  = {8'h00, r[15:8]};
      lsu_cmd_read  = r[2];
      lsu_cmd_wmask = r[19:16];
      lsu_cmd_wdata = $random(seed);
    end
    r = $random(seed);
    ifu_rsp_ready = (phase == 2) ? r[0] : 1'b1;
    lsu_rsp_ready = (phase == 2) ? r[1] : 1'b1;
  endtask

  //////////////////////////////////////////////////
  // Checks and reference model
  //////////////////////////////////////////////////

  task automatic sample_outputs();
    logic [4:0] row;
    bit         lane;
    bit         any_valid;
    any_valid = ifu_cmd_valid | lsu_cmd_valid;
    if (any_valid && !o_itcm_active)
      report_failure("activity low while a command is valid");
    if (!any_valid && ifu_exp_q.size() == 0 && lsu_exp_q.size() == 0 && o_itcm_active)
      report_failure("activity high with the controller idle");
    if (ifu_cmd_valid && lsu_cmd_valid && o_ifu_cmd_ready)
      report_failure("IFU ready while the LSU command is valid");

    // Effects of last cycle's transfers
    if (ifu_took && !o_ifu_rsp_valid)
      report_failure("IFU response missing one cycle after its command");
    if (lsu_took && !o_lsu_rsp_valid)
      report_failure("LSU response missing one cycle after its command");
    if (ifu_took && !o_ifu_holdup)
      report_failure("holdup low after an IFU command transfer");
    if (lsu_took && o_ifu_holdup)
      report_failure("holdup high after an LSU command transfer");

    if (ifu_held && !o_ifu_rsp_valid)
      report_failure("IFU response dropped before its transfer");
    else if (ifu_held && o_ifu_rsp_rdata !== ifu_held_data)
      report_mismatch("ifu_rsp_stable", ifu_held_data, o_ifu_rsp_rdata);
    if (lsu_held && !o_lsu_rsp_valid)
      report_failure("LSU response dropped before its transfer");
    else if (lsu_held && o_lsu_rsp_rdata !== lsu_held_data)
      report_mismatch("lsu_rsp_stable", {32'h0, lsu_held_data}, {32'h0, o_lsu_rsp_rdata});

    if (o_ifu_rsp_valid && ifu_rsp_ready) begin
      if (ifu_exp_q.size() == 0) begin
        report_failure("IFU response with no command outstanding");
      end else begin
        if (ifu_rd_q[0]) begin
          checks++;
          if (o_ifu_rsp_rdata !== ifu_exp_q[0])
            report_mismatch("ifu_read", ifu_exp_q[0], o_ifu_rsp_rdata);
        end
        void'(ifu_exp_q.pop_front());
        void'(ifu_rd_q.pop_front());
      end
    end
    if (o_lsu_rsp_valid && lsu_rsp_ready) begin
      if (lsu_exp_q.size() == 0) begin
        report_failure("LSU response with no command outstanding");
      end else begin
        if (lsu_rd_q[0]) begin
          checks++;
          if (o_lsu_rsp_rdata !== lsu_exp_q[0])
            report_mismatch("lsu_read", {32'h0, lsu_exp_q[0]}, {32'h0, o_lsu_rsp_rdata});
        end
        void'(lsu_exp_q.pop_front());
        void'(lsu_rd_q.pop_front());
      end
    end
    ifu_held      = o_ifu_rsp_valid & ~ifu_rsp_ready;
    ifu_held_data = o_ifu_rsp_rdata;
    lsu_held      = o_lsu_rsp_valid & ~lsu_rsp_ready;
    lsu_held_data = o_lsu_rsp_rdata;

    // Commands that transfer on the coming edge
    ifu_took = ifu_cmd_valid & o_ifu_cmd_ready;
    lsu_took = lsu_cmd_valid & o_lsu_cmd_ready;
    if (ram_cs !== (ifu_took | lsu_took))
      report_failure("SRAM select does not match a command transfer");
    if (lsu_took) begin
      row  = lsu_cmd_addr[7:3];
      lane = lsu_cmd_addr[LANE_SEL_BIT];
      lsu_exp_q.push_back(ref_mem[row].lane[lane]);
      lsu_rd_q.push_back(lsu_cmd_read);
      if (!lsu_cmd_read) begin
        for (int b = 0; b < LSU_WMSK_W; b++) begin
          if (lsu_cmd_wmask[b])
            ref_mem[row].lane[lane][b*8 +: 8] = lsu_cmd_wdata[b*8 +: 8];
        end
      end
    end
    if (ifu_took) begin
      row = ifu_cmd_addr[7:3];
      ifu_exp_q.push_back(ref_mem[row].word);
      ifu_rd_q.push_back(ifu_cmd_read);
      if (!ifu_cmd_read) begin
        for (int b = 0; b < ITCM_WMSK_W; b++) begin
          if (ifu_cmd_wmask[b])
            ref_mem[row].word[b*8 +: 8] = ifu_cmd_wdata[b*8 +: 8];
        end
      end
    end

    // A command that never gets accepted ends the run
    ifu_stall = (ifu_cmd_valid && !ifu_took) ? ifu_stall + 1 : 0;
    lsu_stall = (lsu_cmd_valid && !lsu_took) ? lsu_stall + 1 : 0;
    if (ifu_stall > 64 || lsu_stall > 64) begin
      report_failure("command not accepted within 64 cycles");
      stuck = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    logic [12:0] r13;
    int          wait_cnt;
    seed = 9323;
    errors = 0;
    checks = 0;
    phase = 0;
    stuck = 1'b0;
    ifu_took = 1'b0;
    lsu_took = 1'b0;
    ifu_held = 1'b0;
    lsu_held = 1'b0;
    ifu_stall = 0;
    lsu_stall = 0;
    rst_n = 1'b0;
    ifu_cmd_valid = 1'b0;
    ifu_cmd_addr = '0;
    ifu_cmd_read = 1'b0;
    ifu_cmd_wdata = '0;
    ifu_cmd_wmask = '0;
    ifu_rsp_ready = 1'b0;
    lsu_cmd_valid = 1'b0;
    lsu_cmd_addr = '0;
    lsu_cmd_read = 1'b0;
    lsu_cmd_wdata = '0;
    lsu_cmd_wmask = '0;
    lsu_rsp_ready = 1'b0;
    for (int i = 0; i < 32; i++) begin
      r13 = 13'(i);
      ref_mem[i].word = {16'hC0DE, 3'b000, r13, 16'hF00D, 3'b000, r13};
    end

    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    if (o_ifu_rsp_valid || o_lsu_rsp_valid || ram_cs || o_ifu_holdup || o_itcm_active)
      report_failure("outputs not idle after reset");

    for (int cyc = 0; cyc < 2000 && !stuck; cyc++) begin
      phase = (cyc < 300) ? 0 : (cyc < 700) ? 1 : 2;
      @(posedge clk);
      #1 drive_inputs();
      @(negedge clk);
      sample_outputs();
    end

    // Let every outstanding response come back
    phase = 3;
    wait_cnt = 0;
    while (!stuck && wait_cnt < 100 && (ifu_cmd_valid || lsu_cmd_valid ||
           ifu_exp_q.size() != 0 || lsu_exp_q.size() != 0)) begin
      @(posedge clk);
      #1 drive_inputs();
      @(negedge clk);
      sample_outputs();
      wait_cnt++;
    end
    if (wait_cnt >= 100)
      report_failure("responses did not drain within 100 cycles");

    $display("errors %0d, read responses checked %0d", errors, checks);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ITCM controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f verilog.f --top-module tb_itcm_ctrl \
  -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" "$LOG"; then
  exit 1
fi

if ! grep -q "test passed" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi

exit 0

// ==== verilog.f ====
verilog/itcm_pkg.sv
verilog/itcm_lsu_n2w.sv
verilog/itcm_port_mux.sv
verilog/itcm_sram_ctrl.sv
verilog/itcm_ctrl.sv
dv/itcm_sram_model.sv
dv/tb_itcm_ctrl.sv

// ==== verilog/itcm_ctrl.sv ====
`timescale 1ns/1ns

module itcm_ctrl
  import itcm_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst_n,

  // IFU port, 64-bit
  input  logic                   i_ifu_cmd_valid,
  output logic                   o_ifu_cmd_ready,
  input  logic [ITCM_ADDR_W-1:0] i_ifu_cmd_addr,
  input  logic                   i_ifu_cmd_read,
  input  logic [ITCM_DATA_W-1:0] i_ifu_cmd_wdata,
  input  logic [ITCM_WMSK_W-1:0] i_ifu_cmd_wmask,
  output logic                   o_ifu_rsp_valid,
  input  logic                   i_ifu_rsp_ready,
  output logic [ITCM_DATA_W-1:0] o_ifu_rsp_rdata,
  output logic                   o_ifu_holdup,

  // LSU port, 32-bit
  input  logic                   i_lsu_cmd_valid,
  output logic                   o_lsu_cmd_ready,
  input  logic [ITCM_ADDR_W-1:0] i_lsu_cmd_addr,
  input  logic                   i_lsu_cmd_read,
  input  logic [LSU_DATA_W-1:0]  i_lsu_cmd_wdata,
  input  logic [LSU_WMSK_W-1:0]  i_lsu_cmd_wmask,
  output logic                   o_lsu_rsp_valid,
  input  logic                   i_lsu_rsp_ready,
  output logic [LSU_DATA_W-1:0]  o_lsu_rsp_rdata,

  // SRAM
  output logic                   o_ram_cs,
  output logic                   o_ram_we,
  output logic [ITCM_RAM_AW-1:0] o_ram_addr,
  output logic [ITCM_WMSK_W-1:0] o_ram_wem,
  output logic [ITCM_DATA_W-1:0] o_ram_din,
  input  logic [ITCM_DATA_W-1:0] i_ram_dout,

  output logic                   o_itcm_active
);

  // LSU traffic after widening
  logic                   lsu_w_cmd_valid;
  logic                   lsu_w_cmd_ready;
  logic [ITCM_ADDR_W-1:0] lsu_w_cmd_addr;
  logic                   lsu_w_cmd_read;
  itcm_word_u             lsu_w_cmd_wdata;
  logic [ITCM_WMSK_W-1:0] lsu_w_cmd_wmask;
  logic                   lsu_w_rsp_valid;
  logic                   lsu_w_rsp_ready;
  itcm_word_u             lsu_w_rsp_rdata;

  // Merged and tagged SRAM traffic
  logic                   sram_cmd_valid;
  logic                   sram_cmd_ready;
  logic [ITCM_ADDR_W-1:0] sram_cmd_addr;
  logic                   sram_cmd_read;
  logic [ITCM_DATA_W-1:0] sram_cmd_wdata;
  logic [ITCM_WMSK_W-1:0] sram_cmd_wmask;
  logic                   sram_cmd_ifu;
  logic                   sram_rsp_valid;
  logic                   sram_rsp_ready;
  logic [ITCM_DATA_W-1:0] sram_rsp_rdata;
  logic                   sram_rsp_ifu;
  logic                   sram_busy;

  //////////////////////////////////////////////////
  // LSU width converter
  //////////////////////////////////////////////////

  itcm_lsu_n2w u_lsu_n2w (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_lsu_cmd_valid (i_lsu_cmd_valid),
    .o_lsu_cmd_ready (o_lsu_cmd_ready),
    .i_lsu_cmd_addr  (i_lsu_cmd_addr),
    .i_lsu_cmd_read  (i_lsu_cmd_read),
    .i_lsu_cmd_wdata (i_lsu_cmd_wdata),
    .i_lsu_cmd_wmask (i_lsu_cmd_wmask),
    .o_lsu_rsp_valid (o_lsu_rsp_valid),
    .i_lsu_rsp_ready (i_lsu_rsp_ready),
    .o_lsu_rsp_rdata (o_lsu_rsp_rdata),
    .o_w_cmd_valid   (lsu_w_cmd_valid),
    .i_w_cmd_ready   (lsu_w_cmd_ready),
    .o_w_cmd_addr    (lsu_w_cmd_addr),
    .o_w_cmd_read    (lsu_w_cmd_read),
    .o_w_cmd_wdata   (lsu_w_cmd_wdata),
    .o_w_cmd_wmask   (lsu_w_cmd_wmask),
    .i_w_rsp_valid   (lsu_w_rsp_valid),
    .o_w_rsp_ready   (lsu_w_rsp_ready),
    .i_w_rsp_rdata   (lsu_w_rsp_rdata)
  );

  //////////////////////////////////////////////////
  // Requester mux
  //////////////////////////////////////////////////

  itcm_port_mux u_port_mux (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_ifu_cmd_valid   (i_ifu_cmd_valid),
    .o_ifu_cmd_ready   (o_ifu_cmd_ready),
    .i_ifu_cmd_addr    (i_ifu_cmd_addr),
    .i_ifu_cmd_read    (i_ifu_cmd_read),
    .i_ifu_cmd_wdata   (i_ifu_cmd_wdata),
    .i_ifu_cmd_wmask   (i_ifu_cmd_wmask),
    .o_ifu_rsp_valid   (o_ifu_rsp_valid),
    .i_ifu_rsp_ready   (i_ifu_rsp_ready),
    .o_ifu_rsp_rdata   (o_ifu_rsp_rdata),
    .i_lsu_w_cmd_valid (lsu_w_cmd_valid),
    .o_lsu_w_cmd_ready (lsu_w_cmd_ready),
    .i_lsu_w_cmd_addr  (lsu_w_cmd_addr),
    .i_lsu_w_cmd_read  (lsu_w_cmd_read),
    .i_lsu_w_cmd_wdata (lsu_w_cmd_wdata),
    .i_lsu_w_cmd_wmask (lsu_w_cmd_wmask),
    .o_lsu_w_rsp_valid (lsu_w_rsp_valid),
    .i_lsu_w_rsp_ready (lsu_w_rsp_ready),
    .o_lsu_w_rsp_rdata (lsu_w_rsp_rdata),
    .o_sram_cmd_valid  (sram_cmd_valid),
    .i_sram_cmd_ready  (sram_cmd_ready),
    .o_sram_cmd_addr   (sram_cmd_addr),
    .o_sram_cmd_read   (sram_cmd_read),
    .o_sram_cmd_wdata  (sram_cmd_wdata),
    .o_sram_cmd_wmask  (sram_cmd_wmask),
    .o_sram_cmd_ifu    (sram_cmd_ifu),
    .i_sram_rsp_valid  (sram_rsp_valid),
    .o_sram_rsp_ready  (sram_rsp_ready),
    .i_sram_rsp_rdata  (sram_rsp_rdata),
    .i_sram_rsp_ifu    (sram_rsp_ifu),
    .o_ifu_holdup      (o_ifu_holdup)
  );

  //////////////////////////////////////////////////
  // SRAM controller
  //////////////////////////////////////////////////

  itcm_sram_ctrl u_sram_ctrl (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_cmd_valid (sram_cmd_valid),
    .o_cmd_ready (sram_cmd_ready),
    .i_cmd_addr  (sram_cmd_addr),
    .i_cmd_read  (sram_cmd_read),
    .i_cmd_wdata (sram_cmd_wdata),
    .i_cmd_wmask (sram_cmd_wmask),
    .i_cmd_ifu   (sram_cmd_ifu),
    .o_rsp_valid (sram_rsp_valid),
    .i_rsp_ready (sram_rsp_ready),
    .o_rsp_rdata (sram_rsp_rdata),
    .o_rsp_ifu   (sram_rsp_ifu),
    .o_ram_cs    (o_ram_cs),
    .o_ram_we    (o_ram_we),
    .o_ram_addr  (o_ram_addr),
    .o_ram_wem   (o_ram_wem),
    .o_ram_din   (o_ram_din),
    .i_ram_dout  (i_ram_dout),
    .o_busy      (sram_busy)
  );

  // Anything requested or still in flight keeps the ITCM awake
  assign o_itcm_active = i_ifu_cmd_valid | i_lsu_cmd_valid | sram_busy;

endmodule

// ==== verilog/itcm_lsu_n2w.sv ====
`timescale 1ns/1ns

module itcm_lsu_n2w
  import itcm_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst_n,

  // Narrow LSU command
  input  logic                   i_lsu_cmd_valid,
  output logic                   o_lsu_cmd_ready,
  input  logic [ITCM_ADDR_W-1:0] i_lsu_cmd_addr,
  input  logic                   i_lsu_cmd_read,
  input  logic [LSU_DATA_W-1:0]  i_lsu_cmd_wdata,
  input  logic [LSU_WMSK_W-1:0]  i_lsu_cmd_wmask,

  // Narrow LSU response
  output logic                   o_lsu_rsp_valid,
  input  logic                   i_lsu_rsp_ready,
  output logic [LSU_DATA_W-1:0]  o_lsu_rsp_rdata,

  // Wide command toward the port mux
  output logic                   o_w_cmd_valid,
  input  logic                   i_w_cmd_ready,
  output logic [ITCM_ADDR_W-1:0] o_w_cmd_addr,
  output logic                   o_w_cmd_read,
  output itcm_word_u             o_w_cmd_wdata,
  output logic [ITCM_WMSK_W-1:0] o_w_cmd_wmask,

  // Wide response from the port mux
  input  logic                   i_w_rsp_valid,
  output logic                   o_w_rsp_ready,
  input  itcm_word_u             i_w_rsp_rdata
);

  logic outs_r;
  logic lane_r;
  logic cmd_lane;
  logic cmd_hsk;
  logic rsp_hsk;
  logic cmd_allow;

  //////////////////////////////////////////////////
  // Command path
  //////////////////////////////////////////////////

  assign cmd_lane = i_lsu_cmd_addr[LANE_SEL_BIT];

  // Only one LSU access in flight, a retiring one frees the slot
  assign rsp_hsk   = i_w_rsp_valid & i_lsu_rsp_ready;
  assign cmd_allow = ~outs_r | rsp_hsk;

  assign o_w_cmd_valid   = i_lsu_cmd_valid & cmd_allow;
  assign o_lsu_cmd_ready = i_w_cmd_ready & cmd_allow;
  assign cmd_hsk         = i_lsu_cmd_valid & o_lsu_cmd_ready;

  assign o_w_cmd_addr = i_lsu_cmd_addr;
  assign o_w_cmd_read = i_lsu_cmd_read;

  // Write data goes to both lanes, the mask decides which bytes land
  always_comb begin
    o_w_cmd_wdata.lane[0] = i_lsu_cmd_wdata;
    o_w_cmd_wdata.lane[1] = i_lsu_cmd_wdata;
  end

  assign o_w_cmd_wmask = cmd_lane ? {i_lsu_cmd_wmask, {LSU_WMSK_W{1'b0}}}
                                  : {{LSU_WMSK_W{1'b0}}, i_lsu_cmd_wmask};

  //////////////////////////////////////////////////
  // Outstanding tracking
  //////////////////////////////////////////////////

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      outs_r <= 1'b0;
    end else if (cmd_hsk) begin
      outs_r <= 1'b1;
    end else if (rsp_hsk) begin
      outs_r <= 1'b0;
    end
  end

  // Lane of the pending access
  always_ff @(posedge i_clk) begin
    if (cmd_hsk) begin
      lane_r <= cmd_lane;
    end
  end

  //////////////////////////////////////////////////
  // Response path
  //////////////////////////////////////////////////

  assign o_lsu_rsp_valid = i_w_rsp_valid;
  assign o_w_rsp_ready   = i_lsu_rsp_ready;
  assign o_lsu_rsp_rdata = i_w_rsp_rdata.lane[lane_r];

endmodule

// ==== verilog/itcm_pkg.sv ====
package itcm_pkg;

  //////////////////////////////////////////////////
  // ITCM geometry
  //////////////////////////////////////////////////

  // Byte address into the ITCM
  localparam int ITCM_ADDR_W = 16;

  // Native ITCM word and byte mask
  localparam int ITCM_DATA_W = 64;
  localparam int ITCM_WMSK_W = ITCM_DATA_W / 8;

  // Load/store side is one lane wide
  localparam int LSU_DATA_W = 32;
  localparam int LSU_WMSK_W = LSU_DATA_W / 8;

  //////////////////////////////////////////////////
  // Address split
  //////////////////////////////////////////////////

  // Row index starts above the byte offset of a 64-bit word
  localparam int ITCM_AW_LSB = 3;
  localparam int ITCM_RAM_AW = ITCM_ADDR_W - ITCM_AW_LSB;

  // Picks the upper or lower 32-bit half
  localparam int LANE_SEL_BIT = 2;

  //////////////////////////////////////////////////
  // Data word
  //////////////////////////////////////////////////

  // Same 64 bits, seen whole or as two lanes
  // lane[0] is bits 31:0
  typedef union packed {
    logic [ITCM_DATA_W-1:0]                     word;
    logic [1:0][LSU_DATA_W-1:0]                 lane;
  } itcm_word_u;

endpackage

// ==== verilog/itcm_port_mux.sv ====
`timescale 1ns/1ns

module itcm_port_mux
  import itcm_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst_n,

  // IFU command
  input  logic                   i_ifu_cmd_valid,
  output logic                   o_ifu_cmd_ready,
  input  logic [ITCM_ADDR_W-1:0] i_ifu_cmd_addr,
  input  logic                   i_ifu_cmd_read,
  input  logic [ITCM_DATA_W-1:0] i_ifu_cmd_wdata,
  input  logic [ITCM_WMSK_W-1:0] i_ifu_cmd_wmask,

  // IFU response
  output logic                   o_ifu_rsp_valid,
  input  logic                   i_ifu_rsp_ready,
  output logic [ITCM_DATA_W-1:0] o_ifu_rsp_rdata,

  // Widened LSU command
  input  logic                   i_lsu_w_cmd_valid,
  output logic                   o_lsu_w_cmd_ready,
  input  logic [ITCM_ADDR_W-1:0] i_lsu_w_cmd_addr,
  input  logic                   i_lsu_w_cmd_read,
  input  logic [ITCM_DATA_W-1:0] i_lsu_w_cmd_wdata,
  input  logic [ITCM_WMSK_W-1:0] i_lsu_w_cmd_wmask,

  // Widened LSU response
  output logic                   o_lsu_w_rsp_valid,
  input  logic                   i_lsu_w_rsp_ready,
  output logic [ITCM_DATA_W-1:0] o_lsu_w_rsp_rdata,

  // Merged command to the SRAM controller
  output logic                   o_sram_cmd_valid,
  input  logic                   i_sram_cmd_ready,
  output logic [ITCM_ADDR_W-1:0] o_sram_cmd_addr,
  output logic                   o_sram_cmd_read,
  output logic [ITCM_DATA_W-1:0] o_sram_cmd_wdata,
  output logic [ITCM_WMSK_W-1:0] o_sram_cmd_wmask,
  output logic                   o_sram_cmd_ifu,

  // Tagged response from the SRAM controller
  input  logic                   i_sram_rsp_valid,
  output logic                   o_sram_rsp_ready,
  input  logic [ITCM_DATA_W-1:0] i_sram_rsp_rdata,
  input  logic                   i_sram_rsp_ifu,

  output logic                   o_ifu_holdup
);

  logic sel_ifu;
  logic sram_cmd_hsk;
  logic holdup_r;

  //////////////////////////////////////////////////
  // Command select
  //////////////////////////////////////////////////

  // Load/store always beats instruction fetch
  assign sel_ifu = i_ifu_cmd_valid & ~i_lsu_w_cmd_valid;

  assign o_ifu_cmd_ready   = ~i_lsu_w_cmd_valid & i_sram_cmd_ready;
  assign o_lsu_w_cmd_ready = i_sram_cmd_ready;

  assign o_sram_cmd_valid = i_lsu_w_cmd_valid | i_ifu_cmd_valid;
  assign o_sram_cmd_ifu   = sel_ifu;

  always_comb begin
    if (i_lsu_w_cmd_valid) begin
      o_sram_cmd_addr  = i_lsu_w_cmd_addr;
      o_sram_cmd_read  = i_lsu_w_cmd_read;
      o_sram_cmd_wdata = i_lsu_w_cmd_wdata;
      o_sram_cmd_wmask = i_lsu_w_cmd_wmask;
    end else begin
      o_sram_cmd_addr  = i_ifu_cmd_addr;
      o_sram_cmd_read  = i_ifu_cmd_read;
      o_sram_cmd_wdata = i_ifu_cmd_wdata;
      o_sram_cmd_wmask = i_ifu_cmd_wmask;
    end
  end

  //////////////////////////////////////////////////
  // Response steering
  //////////////////////////////////////////////////

  // Tag came back with the data, it picks the owner
  assign o_ifu_rsp_valid   = i_sram_rsp_valid & i_sram_rsp_ifu;
  assign o_lsu_w_rsp_valid = i_sram_rsp_valid & ~i_sram_rsp_ifu;
  assign o_sram_rsp_ready  = i_sram_rsp_ifu ? i_ifu_rsp_ready : i_lsu_w_rsp_ready;

  assign o_ifu_rsp_rdata   = i_sram_rsp_rdata;
  assign o_lsu_w_rsp_rdata = i_sram_rsp_rdata;

  //////////////////////////////////////////////////
  // IFU holdup
  //////////////////////////////////////////////////

  // High while the last SRAM access came from the IFU,
  // so the fetch side may reuse the SRAM output
  assign sram_cmd_hsk = o_sram_cmd_valid & i_sram_cmd_ready;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      holdup_r <= 1'b0;
    end else if (sram_cmd_hsk) begin
      holdup_r <= sel_ifu;
    end
  end

  assign o_ifu_holdup = holdup_r;

endmodule

// ==== verilog/itcm_sram_ctrl.sv ====
`timescale 1ns/1ns

module itcm_sram_ctrl
  import itcm_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst_n,

  // Command in
  input  logic                   i_cmd_valid,
  output logic                   o_cmd_ready,
  input  logic [ITCM_ADDR_W-1:0] i_cmd_addr,
  input  logic                   i_cmd_read,
  input  logic [ITCM_DATA_W-1:0] i_cmd_wdata,
  input  logic [ITCM_WMSK_W-1:0] i_cmd_wmask,
  input  logic                   i_cmd_ifu,

  // Response out
  output logic                   o_rsp_valid,
  input  logic                   i_rsp_ready,
  output logic [ITCM_DATA_W-1:0] o_rsp_rdata,
  output logic                   o_rsp_ifu,

  // SRAM macro
  output logic                   o_ram_cs,
  output logic                   o_ram_we,
  output logic [ITCM_RAM_AW-1:0] o_ram_addr,
  output logic [ITCM_WMSK_W-1:0] o_ram_wem,
  output logic [ITCM_DATA_W-1:0] o_ram_din,
  input  logic [ITCM_DATA_W-1:0] i_ram_dout,

  output logic                   o_busy
);

  logic rsp_valid_r;
  logic rsp_ifu_r;
  logic cmd_hsk;
  logic rsp_hsk;

  //////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////

  assign rsp_hsk = rsp_valid_r & i_rsp_ready;

  // One response slot, freed in the same cycle it drains
  assign o_cmd_ready = ~rsp_valid_r | rsp_hsk;
  assign cmd_hsk     = i_cmd_valid & o_cmd_ready;

  //////////////////////////////////////////////////
  // SRAM strobes
  //////////////////////////////////////////////////

  assign o_ram_cs   = cmd_hsk;
  assign o_ram_we   = ~i_cmd_read;
  assign o_ram_addr = i_cmd_addr[ITCM_AW_LSB +: ITCM_RAM_AW];
  assign o_ram_wem  = i_cmd_wmask;
  assign o_ram_din  = i_cmd_wdata;

  //////////////////////////////////////////////////
  // Response stage
  //////////////////////////////////////////////////

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rsp_valid_r <= 1'b0;
      rsp_ifu_r   <= 1'b0;
    end else if (cmd_hsk) begin
      rsp_valid_r <= 1'b1;
      rsp_ifu_r   <= i_cmd_ifu;
    end else if (rsp_hsk) begin
      rsp_valid_r <= 1'b0;
    end
  end

  assign o_rsp_valid = rsp_valid_r;
  assign o_rsp_ifu   = rsp_ifu_r;

  // Macro output holds while cs is low, no capture register
  assign o_rsp_rdata = i_ram_dout;

  assign o_busy = rsp_valid_r;

endmodule
